//--- hw/cache_pkg.sv
package cache_pkg;

    // cache geometry
    localparam int WORD_W          = 32;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int BLOCK_W         = WORD_W * WORDS_PER_BLOCK;
    localparam int OFFSET_W        = 2;
    localparam int NUM_SETS        = 4;
    localparam int SET_W           = 2;
    localparam int NUM_WAYS        = 2;
    localparam int PROC_ADDR_W     = 30;
    localparam int TAG_W           = PROC_ADDR_W - SET_W - OFFSET_W;
    localparam int MEM_ADDR_W      = PROC_ADDR_W - OFFSET_W;

    typedef logic [WORD_W-1:0]  word_t;

    // word 0 sits in the low bits
    typedef logic [BLOCK_W-1:0] block_t;

    // same layout as the processor word address
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [SET_W-1:0]    set;
        logic [OFFSET_W-1:0] word;
    } addr_fields_t;

    // request levels and payload toward main memory
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [MEM_ADDR_W-1:0] addr;
        block_t                wdata;
    } mem_req_t;

    // result of the tag compare for the addressed set
    typedef struct packed {
        logic             hit;
        logic             hit_way;
        logic             victim_way;
        logic             victim_dirty;
        logic [TAG_W-1:0] victim_tag;
    } lookup_t;

    typedef enum logic [1:0] {
        ST_COMPARE,
        ST_WRITEBACK,
        ST_ALLOCATE
    } ctrl_state_e;

    // update applied by both arrays at the rising edge
    typedef enum logic [1:0] {
        OP_NONE,
        OP_WRITE_WORD,
        OP_FILL,
        OP_CLEAN
    } array_op_e;

endpackage

//--- hw/cache_tag_array.sv
module cache_tag_array import cache_pkg::*; (
    input  logic         clk,
    input  logic         proc_reset,
    input  addr_fields_t fields,
    input  array_op_e    op,
    input  logic         way,
    output lookup_t      lookup
);

    logic [TAG_W-1:0]    tag_q   [NUM_SETS][NUM_WAYS];
    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];
    logic [NUM_WAYS-1:0] dirty_q [NUM_SETS];
    logic                lru_q   [NUM_SETS];

    logic [NUM_WAYS-1:0] way_hit;
    logic [NUM_WAYS-1:0] set_valid;
    logic [NUM_WAYS-1:0] set_dirty;
    logic                victim;

    assign set_valid = valid_q[fields.set];
    assign set_dirty = dirty_q[fields.set];

    // a way only hits when it holds valid data
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = set_valid[w] && (tag_q[fields.set][w] == fields.tag);
        end
    end

    // fill empty ways first, then evict the least recently used one
    always_comb begin
        if (!set_valid[0]) begin
            victim = 1'b0;
        end else if (!set_valid[1]) begin
            victim = 1'b1;
        end else begin
            victim = lru_q[fields.set];
        end
    end

    assign lookup.hit          = |way_hit;
    assign lookup.hit_way      = way_hit[1];
    assign lookup.victim_way   = victim;
    assign lookup.victim_dirty = set_valid[victim] && set_dirty[victim];
    assign lookup.victim_tag   = tag_q[fields.set][victim];

    // control bits
    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
                lru_q[s]   <= 1'b0;
            end
        end else begin
            case (op)
                OP_WRITE_WORD: dirty_q[fields.set][way] <= 1'b1;
                OP_FILL: begin
                    valid_q[fields.set][way] <= 1'b1;
                    dirty_q[fields.set][way] <= 1'b0;
                end
                OP_CLEAN: dirty_q[fields.set][way] <= 1'b0;
                default: ;
            endcase
            // lru names the way to evict next
            if (op == OP_FILL) begin
                lru_q[fields.set] <= ~way;
            end else if (lookup.hit) begin
                lru_q[fields.set] <= ~lookup.hit_way;
            end
        end
    end

    // tag loaded on each refill
    always_ff @(posedge clk) begin
        if (op == OP_FILL) begin
            tag_q[fields.set][way] <= fields.tag;
        end
    end

    // a block is only ever filled into the victim way, never duplicated
    a_single_hit: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(way_hit[0] && way_hit[1])
    );

endmodule

//--- hw/cache_data_array.sv
module cache_data_array import cache_pkg::*; (
    input  logic         clk,
    input  addr_fields_t fields,
    input  array_op_e    op,
    input  logic         way,
    input  word_t        wdata,
    input  block_t       fill_block,
    output word_t        rd_word,
    output block_t       victim_block
);

    block_t blocks_q [NUM_SETS][NUM_WAYS];
    block_t sel_block;
    block_t merged;

    assign sel_block    = blocks_q[fields.set][way];
    assign victim_block = sel_block;

    // addressed word of the selected way
    always_comb begin
        rd_word = '0;
        for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
            if (fields.word == OFFSET_W'(i)) begin
                rd_word = sel_block[i*WORD_W +: WORD_W];
            end
        end
    end

    // write hit replaces one word, keeps the rest
    always_comb begin
        merged = sel_block;
        for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
            if (fields.word == OFFSET_W'(i)) begin
                merged[i*WORD_W +: WORD_W] = wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (op)
            OP_WRITE_WORD: blocks_q[fields.set][way] <= merged;
            OP_FILL:       blocks_q[fields.set][way] <= fill_block;
            default: ;
        endcase
    end

endmodule

//--- hw/cache_controller.sv
module cache_controller import cache_pkg::*; (
    input  logic         clk,
    input  logic         proc_reset,
    input  logic         proc_read,
    input  logic         proc_write,
    input  addr_fields_t fields,
    input  lookup_t      lookup,
    input  block_t       victim_block,
    input  word_t        rd_word,
    input  logic         mem_ready,
    output array_op_e    op,
    output logic         way,
    output mem_req_t     mem_req,
    output logic         proc_stall,
    output word_t        proc_rdata
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        access;

    assign access = proc_read || proc_write;

    // hit way while comparing, otherwise the victim stays selected
    assign way = (state_q == ST_COMPARE && lookup.hit) ? lookup.hit_way
                                                       : lookup.victim_way;

    always_comb begin
        state_d       = state_q;
        op            = OP_NONE;
        proc_stall    = 1'b0;
        proc_rdata    = '0;
        mem_req.read  = 1'b0;
        mem_req.write = 1'b0;
        mem_req.addr  = {fields.tag, fields.set};
        mem_req.wdata = '0;

        case (state_q)
            ST_COMPARE: begin
                if (access && lookup.hit) begin
                    if (proc_read) begin
                        proc_rdata = rd_word;
                    end else begin
                        op = OP_WRITE_WORD;
                    end
                end else if (access) begin
                    proc_stall = 1'b1;
                    // dirty victims go back to memory before the refill
                    if (lookup.victim_dirty) begin
                        state_d = ST_WRITEBACK;
                    end else begin
                        state_d = ST_ALLOCATE;
                    end
                end
            end

            ST_WRITEBACK: begin
                proc_stall    = 1'b1;
                mem_req.write = 1'b1;
                mem_req.addr  = {lookup.victim_tag, fields.set};
                mem_req.wdata = victim_block;
                if (mem_ready) begin
                    op      = OP_CLEAN;
                    state_d = ST_ALLOCATE;
                end
            end

            ST_ALLOCATE: begin
                proc_stall   = 1'b1;
                mem_req.read = 1'b1;
                // refill block comes straight from mem_rdata
                if (mem_ready) begin
                    op      = OP_FILL;
                    state_d = ST_COMPARE;
                end
            end

            default: begin
                state_d = ST_COMPARE;
            end
        endcase
    end

    always_ff @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            state_q <= ST_COMPARE;
        end else begin
            state_q <= state_d;
        end
    end

    a_proc_one_op: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(proc_read && proc_write)
    );

    a_mem_one_op: assert property (
        @(posedge clk) disable iff (proc_reset)
        !(mem_req.read && mem_req.write)
    );

    // relies on the processor holding its address while stalled
    a_mem_addr_hold: assert property (
        @(posedge clk) disable iff (proc_reset)
        (mem_req.read || mem_req.write) && !mem_ready |=> $stable(mem_req.addr)
    );

endmodule

//--- hw/cache_top.sv
module cache_top import cache_pkg::*; (
    input  logic                   clk,
    input  logic                   proc_reset,
    input  logic                   proc_read,
    input  logic                   proc_write,
    input  logic [PROC_ADDR_W-1:0] proc_addr,
    input  word_t                  proc_wdata,
    output logic                   proc_stall,
    output word_t                  proc_rdata,
    output logic                   mem_read,
    output logic                   mem_write,
    output logic [MEM_ADDR_W-1:0]  mem_addr,
    output block_t                 mem_wdata,
    input  block_t                 mem_rdata,
    input  logic                   mem_ready
);

    addr_fields_t fields;
    lookup_t      lookup;
    array_op_e    op;
    logic         way;
    word_t        rd_word;
    block_t       victim_block;
    mem_req_t     mem_req;

    // tag, set and word offset of the word address
    assign fields = addr_fields_t'(proc_addr);

    assign mem_read  = mem_req.read;
    assign mem_write = mem_req.write;
    assign mem_addr  = mem_req.addr;
    assign mem_wdata = mem_req.wdata;

    cache_tag_array u_tag_array (
        .clk        (clk),
        .proc_reset (proc_reset),
        .fields     (fields),
        .op         (op),
        .way        (way),
        .lookup     (lookup)
    );

    cache_data_array u_data_array (
        .clk          (clk),
        .fields       (fields),
        .op           (op),
        .way          (way),
        .wdata        (proc_wdata),
        .fill_block   (mem_rdata),
        .rd_word      (rd_word),
        .victim_block (victim_block)
    );

    cache_controller u_controller (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .proc_read    (proc_read),
        .proc_write   (proc_write),
        .fields       (fields),
        .lookup       (lookup),
        .victim_block (victim_block),
        .rd_word      (rd_word),
        .mem_ready    (mem_ready),
        .op           (op),
        .way          (way),
        .mem_req      (mem_req),
        .proc_stall   (proc_stall),
        .proc_rdata   (proc_rdata)
    );

endmodule

//--- verif/tb_mem_model.sv
module tb_mem_model import cache_pkg::*; (
    input  logic                  clk,
    input  logic                  proc_reset,
    input  logic                  mem_read,
    input  logic                  mem_write,
    input  logic [MEM_ADDR_W-1:0] mem_addr,
    input  block_t                mem_wdata,
    output block_t                mem_rdata,
    output logic                  mem_ready,
    output int                    wb_count
);

    // only written blocks are stored, the rest follow the fill pattern
    block_t store [logic [MEM_ADDR_W-1:0]];
    int     delay;
    integer seed = 32'h4c2e_2eb4;

    // word i of block b holds its own word address xor a constant
    function automatic block_t pattern_block(input logic [MEM_ADDR_W-1:0] b);
        block_t blk;
        word_t  addr_word;
        blk = '0;
        for (int i = 0; i < WORDS_PER_BLOCK; i++) begin
            addr_word = {2'b00, b, 2'(i)};
            blk[i*WORD_W +: WORD_W] = addr_word ^ 32'h5a5a_0000;
        end
        return blk;
    endfunction

    always @(posedge clk or posedge proc_reset) begin
        if (proc_reset) begin
            mem_ready <= 1'b0;
            mem_rdata <= '0;
            wb_count  <= 0;
            delay     <= int'({$random(seed)} % 4);
        end else if (mem_ready) begin
            // request completes on this edge
            mem_ready <= 1'b0;
            delay     <= int'({$random(seed)} % 4);
            if (mem_write) begin
                store[mem_addr] = mem_wdata;
                wb_count <= wb_count + 1;
            end
        end else if (mem_read || mem_write) begin
            if (delay == 0) begin
                mem_ready <= 1'b1;
                if (store.exists(mem_addr)) begin
                    mem_rdata <= store[mem_addr];
                end else begin
                    mem_rdata <= pattern_block(mem_addr);
                end
            end else begin
                delay <= delay - 1;
            end
        end
    end

endmodule

//--- verif/cache_tb.sv
module cache_tb import cache_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 200;
    localparam int RAND_OPS       = 40;

    typedef struct {
        string                  name;
        logic                   is_write;
        logic [PROC_ADDR_W-1:0] addr;
        word_t                  wdata;
        word_t                  exp_word;
        logic                   exp_stall;
        int                     exp_wb;
    } test_entry_t;

    logic                   clk;
    logic                   proc_reset;
    logic                   proc_read;
    logic                   proc_write;
    logic [PROC_ADDR_W-1:0] proc_addr;
    word_t                  proc_wdata;
    logic                   proc_stall;
    word_t                  proc_rdata;
    logic                   mem_read;
    logic                   mem_write;
    logic [MEM_ADDR_W-1:0]  mem_addr;
    block_t                 mem_wdata;
    block_t                 mem_rdata;
    logic                   mem_ready;
    int                     wb_count;

    test_entry_t table_q[$];
    word_t       shadow [logic [PROC_ADDR_W-1:0]];
    int          errors;
    int          tests;
    bit          timed_out;
    integer      seed = 32'h4c2e_2eb4;

    cache_top u_cache_top (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    tb_mem_model u_mem (
        .clk        (clk),
        .proc_reset (proc_reset),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .wb_count   (wb_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // memory contents before any write
    function automatic word_t pattern_word(input logic [PROC_ADDR_W-1:0] addr);
        return {2'b00, addr} ^ 32'h5a5a_0000;
    endfunction

    function automatic word_t expected_word(input logic [PROC_ADDR_W-1:0] addr);
        if (shadow.exists(addr)) begin
            return shadow[addr];
        end
        return pattern_word(addr);
    endfunction

    task automatic check_word(input string name, input string what,
                              input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %08h, actual %08h", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input string what,
                               input int exp, input int act);
        if (act != exp) begin
            $display("Mismatch %s %s: expected %0d, actual %0d", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input string what,
                             input logic exp, input logic act);
        if (act !== exp) begin
            $display("Mismatch %s %s: expected %b, actual %b", name, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: error", name);
        end
    endtask

    task automatic add_entry(input string name, input logic is_write,
                             input logic [PROC_ADDR_W-1:0] addr, input word_t wdata,
                             input word_t exp_word, input logic exp_stall, input int exp_wb);
        test_entry_t t;
        t.name      = name;
        t.is_write  = is_write;
        t.addr      = addr;
        t.wdata     = wdata;
        t.exp_word  = exp_word;
        t.exp_stall = exp_stall;
        t.exp_wb    = exp_wb;
        table_q.push_back(t);
    endtask

    // holds the request until proc_stall is low at a falling edge
    task automatic run_access(input logic is_write, input logic [PROC_ADDR_W-1:0] addr,
                              input word_t wdata, output logic first_stall,
                              output word_t rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        proc_read  <= !is_write;
        proc_write <= is_write;
        proc_addr  <= addr;
        proc_wdata <= wdata;
        @(negedge clk);
        first_stall = proc_stall;
        while (proc_stall === 1'b1 && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            waited++;
        end
        if (proc_stall !== 1'b0) begin
            timed_out = 1'b1;
        end
        rdata = proc_rdata;
    endtask

    initial begin
        test_entry_t            t;
        word_t                  rdata;
        word_t                  rnd;
        word_t                  wdata;
        logic                   first_stall;
        logic                   is_write;
        logic [PROC_ADDR_W-1:0] addr;
        int                     errs_before;
        string                  name;

        errors      = 0;
        tests       = 0;
        timed_out   = 1'b0;
        proc_reset <= 1'b1;
        proc_read  <= 1'b0;
        proc_write <= 1'b0;
        proc_addr  <= '0;
        proc_wdata <= '0;
        repeat (4) @(posedge clk);
        proc_reset <= 1'b0;

        @(negedge clk);
        errs_before = errors;
        check_bit("reset_idle", "proc_stall", 1'b0, proc_stall);
        check_bit("reset_idle", "mem_read", 1'b0, mem_read);
        check_bit("reset_idle", "mem_write", 1'b0, mem_write);
        check_word("reset_idle", "proc_rdata", '0, proc_rdata);
        report_test("reset_idle", errs_before);

        // set 1 holds tags 0x10, 0x20 and 0x30 in turn
        add_entry("cold_read", 1'b0, 30'h106, '0, pattern_word(30'h106), 1'b1, 0);
        add_entry("same_block", 1'b0, 30'h105, '0, pattern_word(30'h105), 1'b0, 0);
        add_entry("write_hit", 1'b1, 30'h107, 32'hdead_beef, '0, 1'b0, 0);
        add_entry("read_back", 1'b0, 30'h107, '0, 32'hdead_beef, 1'b0, 0);
        add_entry("second_way", 1'b0, 30'h204, '0, pattern_word(30'h204), 1'b1, 0);
        add_entry("evict_dirty", 1'b0, 30'h305, '0, pattern_word(30'h305), 1'b1, 1);
        add_entry("evicted_read", 1'b0, 30'h107, '0, 32'hdead_beef, 1'b1, 1);

        foreach (table_q[i]) begin
            if (timed_out) begin
                break;
            end
            t = table_q[i];
            errs_before = errors;
            run_access(t.is_write, t.addr, t.wdata, first_stall, rdata);
            if (timed_out) begin
                $display("%s: no response, proc_stall still high after %0d cycles",
                         t.name, TIMEOUT_CYCLES);
                errors++;
            end else begin
                check_bit(t.name, "first-cycle stall", t.exp_stall, first_stall);
                if (t.is_write) begin
                    shadow[t.addr] = t.wdata;
                end else begin
                    check_word(t.name, "read data", t.exp_word, rdata);
                end
                check_count(t.name, "write-backs", t.exp_wb, wb_count);
            end
            report_test(t.name, errs_before);
        end

        // four tags per set over sets 2 and 3 force evictions
        for (int n = 0; n < RAND_OPS; n++) begin
            if (timed_out) begin
                break;
            end
            rnd      = $random(seed);
            wdata    = $random(seed);
            is_write = rnd[0];
            addr     = {24'h00_0001, rnd[5:4], 1'b1, rnd[1], rnd[3:2]};
            name     = $sformatf("rand_%0d", n);
            errs_before = errors;
            run_access(is_write, addr, wdata, first_stall, rdata);
            if (timed_out) begin
                $display("%s: no response, proc_stall still high after %0d cycles",
                         name, TIMEOUT_CYCLES);
                errors++;
            end else if (is_write) begin
                shadow[addr] = wdata;
            end else begin
                check_word(name, "read data", expected_word(addr), rdata);
            end
            report_test(name, errs_before);
        end

        @(posedge clk);
        proc_read  <= 1'b0;
        proc_write <= 1'b0;
        @(posedge clk);
        $display("tests: %0d, errors: %0d", tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- project.f
hw/cache_pkg.sv
hw/cache_tag_array.sv
hw/cache_data_array.sv
hw/cache_controller.sv
hw/cache_top.sv
verif/tb_mem_model.sv
verif/cache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cache testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f project.f --top-module cache_tb -o cache_tb_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/cache_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi

if ! grep -q "Test passed" "$LOG"; then
    echo "simulation ended without a result line"
    exit 1
fi

exit 0
